//--- files.f
wb_pkg.sv
mem_req_if.sv
wb_if.sv
wb_master.sv
pipe_stall_ctrl.sv
mem_stage.sv
wb_sram.sv
mem_subsys_top.sv
wb_master_checker.sv
tb_mem_subsys.sv

//--- mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
	import wb_pkg::*;

	logic              ce;		// Access request, held until ack
	logic [DATA_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              we;
	logic [SEL_W-1:0]  sel;
	logic [DATA_W-1:0] rdata;
	logic              ack;

	// Memory stage side
	modport master (
		output ce, addr, wdata, we, sel,
		input  rdata, ack
	);

	// Bus master side
	modport slave (
		input  ce, addr, wdata, we, sel,
		output rdata, ack
	);

endinterface

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       req_valid_i,
	input  logic [wb_pkg::DATA_W-1:0]  req_addr_i,
	input  logic [wb_pkg::DATA_W-1:0]  req_wdata_i,
	input  logic                       req_we_i,
	input  logic [wb_pkg::SEL_W-1:0]   req_sel_i,
	output logic                       req_ready_o,
	output logic                       resp_valid_o,
	output logic [wb_pkg::DATA_W-1:0]  resp_rdata_o,
	input  logic                       resp_ready_i,
	input  logic [wb_pkg::STALL_W-1:0] stall_i,
	input  logic                       flush_i,
	mem_req_if.master                  mem
);
	import wb_pkg::*;

	logic              req_full;		// Request handed to the bus master
	logic              resp_full;		// Response waiting for the consumer
	logic              wait_rel;		// Acked under stall, waiting for release
	logic [DATA_W-1:0] resp_data;
	logic              accept;
	logic              done;
	logic              deliver;

	assign req_ready_o  = !req_full && !resp_full;
	assign accept       = req_valid_i && req_ready_o;
	assign done         = req_full && mem.ack;
	assign resp_valid_o = resp_full && !wait_rel && !stall_i[MEM_STALL_BIT];
	assign deliver      = resp_valid_o && resp_ready_i;
	assign resp_rdata_o = resp_data;
	assign mem.ce       = req_full;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			req_full  <= 1'b0;
			resp_full <= 1'b0;
			wait_rel  <= 1'b0;
		end else begin
			if (accept) begin
				req_full <= 1'b1;
			end else if (done) begin
				// Ack wins over a flush in the same cycle, as in the master
				req_full  <= 1'b0;
				resp_full <= 1'b1;
				wait_rel  <= (stall_i != '0);
			end else if (req_full && flush_i) begin
				req_full <= 1'b0;		// Dropped, no response
			end
			if (deliver) begin
				resp_full <= 1'b0;
			end
			if (wait_rel && (stall_i == '0)) begin
				wait_rel <= 1'b0;
			end
		end
	end

	// Request fields and response word
	always_ff @(posedge clk) begin
		if (accept) begin
			mem.addr  <= req_addr_i;
			mem.wdata <= req_wdata_i;
			mem.we    <= req_we_i;
			mem.sel   <= req_sel_i;
		end
		if (done) begin
			resp_data <= mem.we ? '0 : mem.rdata;		// Stores return zero
		end
	end

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       req_valid_i,
	output logic                       req_ready_o,
	input  logic [wb_pkg::DATA_W-1:0]  req_addr_i,
	input  logic [wb_pkg::DATA_W-1:0]  req_wdata_i,
	input  logic                       req_we_i,
	input  logic [wb_pkg::SEL_W-1:0]   req_sel_i,
	output logic                       resp_valid_o,
	input  logic                       resp_ready_i,
	output logic [wb_pkg::DATA_W-1:0]  resp_rdata_o,
	input  logic                       flush_i,
	input  logic                       ext_stall_i,
	output logic [wb_pkg::STALL_W-1:0] stall_o
);

	logic stallreq;		// Bus master wants the pipeline held
	logic flush;

	mem_req_if mem_req_bus ();
	wb_if      wb_bus ();

	mem_stage mem_stage_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.req_valid_i  (req_valid_i),
		.req_addr_i   (req_addr_i),
		.req_wdata_i  (req_wdata_i),
		.req_we_i     (req_we_i),
		.req_sel_i    (req_sel_i),
		.req_ready_o  (req_ready_o),
		.resp_valid_o (resp_valid_o),
		.resp_rdata_o (resp_rdata_o),
		.resp_ready_i (resp_ready_i),
		.stall_i      (stall_o),
		.flush_i      (flush),
		.mem          (mem_req_bus)
	);

	wb_master wb_master_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.stall_i    (stall_o),
		.flush_i    (flush),
		.req        (mem_req_bus),
		.bus        (wb_bus),
		.stallreq_o (stallreq)
	);

	pipe_stall_ctrl pipe_stall_ctrl_inst (
		.stallreq_mem_i (stallreq),
		.stall_fetch_i  (ext_stall_i),
		.flush_req_i    (flush_i),
		.stall_o        (stall_o),
		.flush_o        (flush)
	);

	wb_sram wb_sram_inst (
		.clk     (clk),
		.reset_i (reset_i),
		.bus     (wb_bus)
	);

endmodule

//--- pipe_stall_ctrl.sv
`timescale 1ns/1ps

module pipe_stall_ctrl (
	input  logic                       stallreq_mem_i,
	input  logic                       stall_fetch_i,
	input  logic                       flush_req_i,
	output logic [wb_pkg::STALL_W-1:0] stall_o,
	output logic                       flush_o
);
	import wb_pkg::*;

	// The flush travels on unchanged to the stages
	assign flush_o = flush_req_i;

	// Priority: flush, then memory, then fetch
	always_comb begin
		if (flush_req_i) begin
			stall_o = '0;		// A flush releases every stage
		end else if (stallreq_mem_i) begin
			stall_o = STALL_MEM;
		end else if (stall_fetch_i) begin
			stall_o = STALL_FETCH;
		end else begin
			stall_o = '0;
		end
	end

	// A memory stall also covers the fetch side, so a pending access
	// always shows STALL_MEM even when the fetch side asks for a stall.

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f files.f \
	&& ./obj_dir/Vtb_mem_subsys +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { echo "Simulation did not build or run cleanly"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Result: no verdict in sim.log"; exit 1; }
echo "Result: PASS"

//--- tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
	import wb_pkg::*;

	logic               clk;
	logic               reset_i;
	logic               req_valid_i;
	logic               req_ready_o;
	logic [DATA_W-1:0]  req_addr_i;
	logic [DATA_W-1:0]  req_wdata_i;
	logic               req_we_i;
	logic [SEL_W-1:0]   req_sel_i;
	logic               resp_valid_o;
	logic               resp_ready_i;
	logic [DATA_W-1:0]  resp_rdata_o;
	logic               flush_i;
	logic               ext_stall_i;
	logic [STALL_W-1:0] stall_o;

	logic [DATA_W-1:0] model_mem [SRAM_WORDS];		// Expected SRAM contents
	logic [DATA_W-1:0] rnd;
	int                value_errors;
	int                timeouts;
	int                bus_fails;
	int                wait_limit;		// Cycles allowed for any single wait
	int                seed;

	mem_subsys_top mem_subsys_top_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.req_addr_i   (req_addr_i),
		.req_wdata_i  (req_wdata_i),
		.req_we_i     (req_we_i),
		.req_sel_i    (req_sel_i),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i),
		.resp_rdata_o (resp_rdata_o),
		.flush_i      (flush_i),
		.ext_stall_i  (ext_stall_i),
		.stall_o      (stall_o)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("FAILED time %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [SRAM_AW-1:0] word_of(input logic [DATA_W-1:0] addr);
		return SRAM_AW'(addr >> 2);		// Four bytes a word, wraps at the depth
	endfunction

	task automatic send_request(input logic we, input logic [DATA_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel);
		int n;
		n = 0;
		while (!req_ready_o && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!req_ready_o) begin
			timeouts++;
			$display("Timeout while waiting for req_ready_o");
		end
		req_valid_i = 1'b1;
		req_we_i    = we;
		req_addr_i  = addr;
		req_wdata_i = wdata;
		req_sel_i   = sel;
		@(negedge clk);		// Taken on the rising edge just passed
		req_valid_i = 1'b0;
	endtask

	task automatic take_response(input logic [DATA_W-1:0] expected, input int hold_cycles);
		int n;
		n = 0;
		while (!resp_valid_o && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!resp_valid_o) begin
			timeouts++;
			$display("Timeout while waiting for resp_valid_o");
		end else begin
			check_word("resp_rdata_o", resp_rdata_o, expected);
			repeat (hold_cycles) begin
				@(negedge clk);
				check_word("resp_valid_o", 32'(resp_valid_o), 32'd1);		// Held by the consumer
				check_word("resp_rdata_o", resp_rdata_o, expected);
				check_word("req_ready_o", 32'(req_ready_o), '0);
			end
		end
		resp_ready_i = 1'b1;
		@(negedge clk);
		check_word("resp_valid_o", 32'(resp_valid_o), '0);
	endtask

	task automatic access(input logic we, input logic [DATA_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel,
			input int hold_cycles);
		logic [DATA_W-1:0] word;
		word = model_mem[word_of(addr)];
		for (int lane = 0; lane < SEL_W; lane++) begin
			if (we && sel[lane]) begin
				word[lane*8 +: 8] = wdata[lane*8 +: 8];
			end
		end
		model_mem[word_of(addr)] = word;
		resp_ready_i = (hold_cycles == 0);
		send_request(we, addr, wdata, sel);
		check_word("stall_o", 32'(stall_o), 32'(STALL_MEM));		// Access in flight
		take_response(we ? '0 : word, hold_cycles);
	endtask

	// Write dropped before its ack, so the old word must survive
	task automatic flush_access(input logic [DATA_W-1:0] addr, input int delay);
		resp_ready_i = 1'b1;
		send_request(1'b1, addr, ~model_mem[word_of(addr)], '1);
		repeat (delay) @(negedge clk);
		flush_i = 1'b1;
		#10;
		check_word("stall_o", 32'(stall_o), '0);
		@(negedge clk);
		flush_i = 1'b0;
		repeat (8) begin
			check_word("resp_valid_o", 32'(resp_valid_o), '0);
			@(negedge clk);
		end
		check_word("req_ready_o", 32'(req_ready_o), 32'd1);
		access(1'b0, addr, '0, '1, 0);
	endtask

	task automatic stalled_read(input logic [DATA_W-1:0] addr);
		ext_stall_i = 1'b1;
		#10;
		check_word("stall_o", 32'(stall_o), 32'(STALL_FETCH));		// Fetch side only
		@(negedge clk);
		resp_ready_i = 1'b1;
		send_request(1'b0, addr, '0, '1);
		check_word("stall_o", 32'(stall_o), 32'(STALL_MEM));
		repeat (8) begin
			@(negedge clk);
			check_word("resp_valid_o", 32'(resp_valid_o), '0);		// Ack came under stall
		end
		check_word("stall_o", 32'(stall_o), 32'(STALL_FETCH));
		ext_stall_i = 1'b0;
		take_response(model_mem[word_of(addr)], 0);
	endtask

	initial begin
		value_errors = 0;
		timeouts     = 0;
		wait_limit   = 40;
		seed         = 60490;
		rnd          = $urandom(seed);
		reset_i      = 1'b1;
		req_valid_i  = 1'b0;
		req_addr_i   = '0;
		req_wdata_i  = '0;
		req_we_i     = 1'b0;
		req_sel_i    = '0;
		resp_ready_i = 1'b1;
		flush_i      = 1'b0;
		ext_stall_i  = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		check_word("req_ready_o", 32'(req_ready_o), 32'd1);
		check_word("resp_valid_o", 32'(resp_valid_o), '0);
		check_word("stall_o", 32'(stall_o), '0);

		for (int i = 0; i < SRAM_WORDS; i++) begin
			rnd = $urandom;
			access(1'b1, DATA_W'(i * 4), rnd, '1, 0);		// Known value in every word
		end

		access(1'b1, 32'h0000_0014, 32'hA1B2_C3D4, 4'b0001, 0);
		access(1'b1, 32'h0000_0014, 32'h5566_7788, 4'b0110, 0);
		access(1'b1, 32'h0000_0014, 32'h99AA_BBCC, 4'b1000, 0);
		access(1'b0, 32'h0000_0014, '0, '1, 0);
		access(1'b1, 32'h0000_0108, 32'hCAFE_F00D, 4'b1111, 0);		// Wraps to word 2
		access(1'b0, 32'h0000_0008, '0, '1, 0);
		access(1'b1, 32'h0000_0020, 32'h1234_5678, 4'b1100, 0);
		access(1'b0, 32'h0000_0020, '0, '1, 0);

		access(1'b0, 32'h0000_0014, '0, '1, 4);
		access(1'b1, 32'h0000_0030, 32'h0BAD_BEEF, 4'b0011, 3);
		access(1'b0, 32'h0000_0030, '0, '1, 2);

		flush_access(32'h0000_0040, 0);		// Before the bus cycle starts
		flush_access(32'h0000_0044, 1);		// With cyc already high
		stalled_read(32'h0000_0014);

		for (int k = 0; k < 200; k++) begin
			rnd = $urandom;
			access(rnd[0], $urandom, $urandom, rnd[7:4], rnd[3] ? int'(rnd[2:1]) : 0);
		end

		repeat (2) @(negedge clk);
		bus_fails = mem_subsys_top_inst.wb_master_inst.wb_master_checker_inst.fail_count;
		$display("Error counts: values %0d, timeouts %0d, bus assertions %0d",
			value_errors, timeouts, bus_fails);
		if (value_errors + timeouts + bus_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- wb_if.sv
`timescale 1ns/1ps

interface wb_if;
	import wb_pkg::*;

	logic              cyc;
	logic              stb;
	logic [DATA_W-1:0] addr;		// Byte address
	logic [DATA_W-1:0] wdata;
	logic              we;
	logic [SEL_W-1:0]  sel;		// One bit per byte lane
	logic [DATA_W-1:0] rdata;
	logic              ack;

	// Single master
	modport master (
		output cyc, stb, addr, wdata, we, sel,
		input  rdata, ack
	);

	// SRAM slave
	modport slave (
		input  cyc, stb, addr, wdata, we, sel,
		output rdata, ack
	);

endinterface

//--- wb_master.sv
`timescale 1ns/1ps

module wb_master (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [wb_pkg::STALL_W-1:0] stall_i,
	input  logic                       flush_i,
	mem_req_if.slave                   req,
	wb_if.master                       bus,
	output logic                       stallreq_o
);
	import wb_pkg::*;

	wb_state_t         state;
	logic [DATA_W-1:0] rd_buf;		// Last word read over the bus
	logic              start;
	logic              finish;

	assign start  = req.ce && !flush_i;
	assign finish = (state == WB_BUSY) && (bus.ack || flush_i);

	// State and cycle control
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state   <= WB_IDLE;
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
		end else begin
			case (state)
				WB_IDLE: begin
					if (start) begin
						bus.cyc <= 1'b1;
						bus.stb <= 1'b1;
						state   <= WB_BUSY;
					end
				end
				WB_BUSY: begin
					if (bus.ack) begin
						bus.cyc <= 1'b0;
						bus.stb <= 1'b0;
						// Hold the read word until the pipeline moves again
						if (stall_i != '0) begin
							state <= WB_WAIT_FOR_STALL;
						end else begin
							state <= WB_IDLE;
						end
					end else if (flush_i) begin
						bus.cyc <= 1'b0;		// Abandon the access
						bus.stb <= 1'b0;
						state   <= WB_IDLE;
					end
				end
				WB_WAIT_FOR_STALL: begin
					if (stall_i == '0) begin
						state <= WB_IDLE;
					end
				end
				default: begin
					state <= WB_IDLE;
				end
			endcase
		end
	end

	// Bus fields, latched at cycle start
	always_ff @(posedge clk) begin
		if ((state == WB_IDLE) && start) begin
			bus.addr  <= req.addr;
			bus.wdata <= req.wdata;
			bus.we    <= req.we;
			bus.sel   <= req.sel;
		end else if (finish) begin
			bus.addr  <= '0;
			bus.wdata <= '0;
			bus.we    <= 1'b0;
			bus.sel   <= '0;
		end
	end

	// Read buffer
	always_ff @(posedge clk) begin
		if ((state == WB_BUSY) && bus.ack) begin
			if (!bus.we) begin
				rd_buf <= bus.rdata;
			end
		end else if ((state == WB_BUSY) && flush_i) begin
			rd_buf <= '0;		// Nothing valid survives a flush
		end
	end

	// Stall request and returned data
	always_comb begin
		stallreq_o = 1'b0;
		req.rdata  = '0;
		case (state)
			WB_IDLE: begin
				stallreq_o = start;
			end
			WB_BUSY: begin
				stallreq_o = !bus.ack;
				if (bus.ack && !bus.we) begin
					req.rdata = bus.rdata;
				end
			end
			WB_WAIT_FOR_STALL: begin
				req.rdata = rd_buf;		// Replay while frozen
			end
			default: begin
				stallreq_o = 1'b0;
			end
		endcase
	end

	assign req.ack = bus.ack;		// Passed through in every state

endmodule

//--- wb_master_checker.sv
`timescale 1ns/1ps

module wb_master_checker (
	input logic                       clk,
	input logic                       reset_i,
	input logic                       flush_i,
	input logic [wb_pkg::STALL_W-1:0] stall_i,
	input wb_pkg::wb_state_t          state_i,
	input logic                       stallreq_i,
	input logic                       cyc_i,
	input logic                       stb_i,
	input logic                       ack_i,
	input logic [wb_pkg::DATA_W-1:0]  addr_i,
	input logic [wb_pkg::DATA_W-1:0]  wdata_i,
	input logic                       we_i,
	input logic [wb_pkg::SEL_W-1:0]   sel_i
);
	import wb_pkg::*;

	int fail_count = 0;		// Failed assertions so far

	fields_stable: assert property (@(posedge clk) disable iff (reset_i)
		(cyc_i && !ack_i && !flush_i) |=> (cyc_i && stb_i && $stable(addr_i)
			&& $stable(wdata_i) && $stable(we_i) && $stable(sel_i)))
	else begin
		fail_count = fail_count + 1;
		$error("bus fields changed while waiting for ack");
	end

	// Single access, so the cycle ends right after ack or flush
	cycle_ends: assert property (@(posedge clk) disable iff (reset_i)
		(cyc_i && (ack_i || flush_i)) |=> !cyc_i)
	else begin
		fail_count = fail_count + 1;
		$error("cyc still high one cycle after ack or flush");
	end

	// The pending access must freeze the pipeline through memory
	busy_stalls: assert property (@(posedge clk) disable iff (reset_i)
		((state_i == WB_BUSY) && !ack_i) |->
			(stallreq_i && (flush_i || (stall_i == STALL_MEM))))
	else begin
		fail_count = fail_count + 1;
		$error("no memory stall while the bus access is pending");
	end

	parked_idle: assert property (@(posedge clk) disable iff (reset_i)
		((state_i == WB_WAIT_FOR_STALL) && (stall_i != '0)) |=>
			((state_i == WB_WAIT_FOR_STALL) && !cyc_i))
	else begin
		fail_count = fail_count + 1;
		$error("master left the stall wait or started a cycle while stalled");
	end

endmodule

bind wb_master wb_master_checker wb_master_checker_inst (
	.clk        (clk),
	.reset_i    (reset_i),
	.flush_i    (flush_i),
	.stall_i    (stall_i),
	.state_i    (state),
	.stallreq_i (stallreq_o),
	.cyc_i      (bus.cyc),
	.stb_i      (bus.stb),
	.ack_i      (bus.ack),
	.addr_i     (bus.addr),
	.wdata_i    (bus.wdata),
	.we_i       (bus.we),
	.sel_i      (bus.sel)
);

//--- wb_pkg.sv
package wb_pkg;

	// Bus geometry
	localparam int DATA_W  = 32;
	localparam int SEL_W   = 4;
	localparam int ADDR_LSB = $clog2(SEL_W);		// Byte offset bits inside a word

	// Stall vector, bit 0 is the PC stage
	localparam int STALL_W = 6;
	localparam logic [STALL_W-1:0] STALL_MEM   = 6'b011111;	// Freeze through memory
	localparam logic [STALL_W-1:0] STALL_FETCH = 6'b000111;	// Freeze through decode
	localparam int MEM_STALL_BIT = 4;

	// On-chip SRAM
	localparam int SRAM_WORDS = 64;
	localparam int SRAM_AW    = $clog2(SRAM_WORDS);
	localparam int SRAM_WAIT  = 2;
	localparam int SRAM_CNT_W = $clog2(SRAM_WAIT + 1);

	// Bus master states
	typedef enum logic [1:0] {
		WB_IDLE           = 2'b00,
		WB_BUSY           = 2'b01,
		WB_WAIT_FOR_STALL = 2'b11
	} wb_state_t;

endpackage

//--- wb_sram.sv
`timescale 1ns/1ps

module wb_sram (
	input  logic clk,
	input  logic reset_i,
	wb_if.slave  bus
);
	import wb_pkg::*;

	logic [DATA_W-1:0]     mem [SRAM_WORDS];
	logic [SRAM_CNT_W-1:0] wait_cnt;		// Cycles since cyc rose
	logic [SRAM_AW-1:0]    word_idx;
	logic                  active;

	// Word address wraps at the SRAM depth
	assign word_idx = bus.addr[ADDR_LSB +: SRAM_AW];
	assign active   = bus.cyc && bus.stb;

	// One cycle ack once the wait states have passed
	assign bus.ack   = active && (wait_cnt == SRAM_CNT_W'(SRAM_WAIT));
	assign bus.rdata = mem[word_idx];

	// Wait-state counter
	always_ff @(posedge clk) begin
		if (reset_i) begin
			wait_cnt <= '0;
		end else if (!active || bus.ack) begin
			wait_cnt <= '0;		// Restart for the next cycle
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Byte-lane writes on the ack edge
	always_ff @(posedge clk) begin
		if (bus.ack && bus.we) begin
			for (int lane = 0; lane < SEL_W; lane++) begin
				if (bus.sel[lane]) begin
					mem[word_idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
				end
			end
		end
	end

endmodule
